// ==== rtl/conv_layer_top.sv ====
`timescale 1ns/1ps

module conv_layer_top #(
	parameter int IMG_W  = 8,
	parameter int OUT_CH = 4,
	parameter int GAP    = 4
) (
	input  logic                                          clk,
	input  logic                                          reset,

	// Pixel stream
	input  logic                                          pxl_valid,
	input  logic [conv_pkg::PIX_W-1:0]                    pxl_in,
	output logic                                          in_ready,

	// Weight load port
	input  logic                                          wgt_we,
	input  logic [$clog2(OUT_CH*conv_pkg::K_TAPS)-1:0]    wgt_addr,
	input  logic signed [conv_pkg::WGT_W-1:0]             wgt_data,

	// Results
	output logic                                          res_valid,
	output logic signed [conv_pkg::ACC_W-1:0]             res_data,
	output logic [$clog2(OUT_CH)-1:0]                     res_channel,
	output logic                                          layer_done
);

	import conv_pkg::*;

	logic                      rp_valid;
	logic [PIX_W-1:0]          rp_pxl;
	logic                      rp_first;
	logic [$clog2(OUT_CH)-1:0] rp_channel;
	logic signed [WGT_W-1:0]   kernel [K_TAPS];

	//////////////////////////////////////////////////////////////////////
	// Frame store and replay
	//////////////////////////////////////////////////////////////////////

	frame_replay_buffer #(
		.IMG_W (IMG_W),
		.OUT_CH(OUT_CH),
		.GAP   (GAP)
	) u_buffer (
		.clk       (clk),
		.reset     (reset),
		.pxl_valid (pxl_valid),
		.pxl_in    (pxl_in),
		.in_ready  (in_ready),
		.rp_valid  (rp_valid),
		.rp_pxl    (rp_pxl),
		.rp_first  (rp_first),
		.rp_channel(rp_channel),
		.layer_done(layer_done)
	);

	// Kernel follows the replayed channel
	kernel_store #(
		.OUT_CH(OUT_CH)
	) u_kernels (
		.clk     (clk),
		.reset   (reset),
		.wgt_we  (wgt_we),
		.wgt_addr(wgt_addr),
		.wgt_data(wgt_data),
		.channel (rp_channel),
		.kernel  (kernel)
	);

	window_mac #(
		.IMG_W (IMG_W),
		.OUT_CH(OUT_CH)
	) u_mac (
		.clk        (clk),
		.reset      (reset),
		.rp_valid   (rp_valid),
		.rp_pxl     (rp_pxl),
		.rp_first   (rp_first),
		.rp_channel (rp_channel),
		.kernel     (kernel),
		.res_valid  (res_valid),
		.res_data   (res_data),
		.res_channel(res_channel)
	);

endmodule

// ==== rtl/conv_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths and types for the convolution layer
//////////////////////////////////////////////////////////////////////

package conv_pkg;

	// Unsigned input pixel
	localparam int PIX_W = 8;

	// Signed kernel weight
	localparam int WGT_W = 8;

	// Nine products of PIX_W+1 by WGT_W bits need 4 guard bits
	localparam int ACC_W = PIX_W + WGT_W + 4;

	// 3x3 kernel, taps in raster order
	localparam int K_TAPS = 9;

	// Frame buffer states
	typedef enum logic [1:0] {
		ST_FILL = 2'd0,
		ST_PASS = 2'd1,
		ST_GAP  = 2'd2,
		ST_DONE = 2'd3
	} replay_state_t;

endpackage

// ==== rtl/frame_replay_buffer.sv ====
`timescale 1ns/1ps

module frame_replay_buffer #(
	parameter int IMG_W  = 8,
	parameter int OUT_CH = 4,
	parameter int GAP    = 4
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         pxl_valid,
	input  logic [conv_pkg::PIX_W-1:0]   pxl_in,
	output logic                         in_ready,
	output logic                         rp_valid,
	output logic [conv_pkg::PIX_W-1:0]   rp_pxl,
	output logic                         rp_first,
	output logic [$clog2(OUT_CH)-1:0]    rp_channel,
	output logic                         layer_done
);

	import conv_pkg::*;

	localparam int NPIX = IMG_W * IMG_W;
	localparam int AW   = $clog2(NPIX);
	localparam int GW   = $clog2(GAP);
	localparam int CH_W = $clog2(OUT_CH);

	localparam logic [AW-1:0]   LAST_ADDR = AW'(NPIX - 1);
	localparam logic [GW-1:0]   GAP_LAST  = GW'(GAP - 1);
	localparam logic [CH_W-1:0] CH_LAST   = CH_W'(OUT_CH - 1);

	replay_state_t state;

	logic [AW-1:0]    addr;
	logic [GW-1:0]    gap_cnt;
	logic             addr_end;
	logic [PIX_W-1:0] mem [NPIX];

	assign in_ready   = (state == ST_FILL);
	assign layer_done = (state == ST_DONE);
	assign addr_end   = (addr == LAST_ADDR);

	//////////////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= ST_FILL;
			addr       <= '0;
			gap_cnt    <= '0;
			rp_channel <= '0;
		end else begin
			case (state)
				ST_FILL: begin
					// Only the pixel count ends the fill
					if (pxl_valid) begin
						addr <= addr_end ? '0 : addr + 1'b1;
						if (addr_end)
							state <= ST_PASS;
					end
				end
				ST_PASS: begin
					addr <= addr_end ? '0 : addr + 1'b1;
					if (addr_end) begin
						gap_cnt <= '0;
						state   <= ST_GAP;
					end
				end
				ST_GAP: begin
					if (gap_cnt == GAP_LAST) begin
						gap_cnt <= '0;
						if (rp_channel == CH_LAST) begin
							state <= ST_DONE;
						end else begin
							// Next channel starts only after the gap
							rp_channel <= rp_channel + 1'b1;
							state      <= ST_PASS;
						end
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				ST_DONE: begin
					rp_channel <= '0;
					state      <= ST_FILL;
				end
				default: state <= ST_FILL;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Frame memory with one cycle read latency
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (in_ready && pxl_valid)
			mem[addr] <= pxl_in;
		rp_pxl <= mem[addr];
	end

	// Valid and first flag line up with the registered read data
	always_ff @(posedge clk) begin
		if (reset) begin
			rp_valid <= 1'b0;
			rp_first <= 1'b0;
		end else begin
			rp_valid <= (state == ST_PASS);
			rp_first <= (state == ST_PASS) && (addr == '0);
		end
	end

	// Source honours in_ready
	a_no_beat_when_busy: assert property (
		@(posedge clk) disable iff (reset) pxl_valid |-> in_ready
	);

	// Channel counter never steps past the last channel
	a_channel_range: assert property (
		@(posedge clk) disable iff (reset)
		(!$past(reset) && ($past(rp_channel) == CH_LAST) && (rp_channel != CH_LAST))
			|-> ($past(state) == ST_DONE)
	);

endmodule

// ==== rtl/kernel_store.sv ====
`timescale 1ns/1ps

module kernel_store #(
	parameter int OUT_CH = 4
) (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic                                          wgt_we,
	input  logic [$clog2(OUT_CH*conv_pkg::K_TAPS)-1:0]    wgt_addr,
	input  logic signed [conv_pkg::WGT_W-1:0]             wgt_data,
	input  logic [$clog2(OUT_CH)-1:0]                     channel,
	output logic signed [conv_pkg::WGT_W-1:0]             kernel [conv_pkg::K_TAPS]
);

	import conv_pkg::*;

	localparam int DEPTH = OUT_CH * K_TAPS;

	logic signed [WGT_W-1:0] weights [DEPTH];

	//////////////////////////////////////////////////////////////////////
	// Weight registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++)
				weights[i] <= '0;
		end else if (wgt_we) begin
			weights[wgt_addr] <= wgt_data;
		end
	end

	// Nine taps of the selected channel
	always_comb begin
		int base;
		base = int'(channel) * K_TAPS;
		for (int t = 0; t < K_TAPS; t++)
			kernel[t] = weights[base + t];
	end

	// Writes land inside the register file
	a_addr_range: assert property (
		@(posedge clk) disable iff (reset) wgt_we |-> (int'(wgt_addr) < DEPTH)
	);

endmodule

// ==== rtl/window_mac.sv ====
`timescale 1ns/1ps

module window_mac #(
	parameter int IMG_W  = 8,
	parameter int OUT_CH = 4
) (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 rp_valid,
	input  logic [conv_pkg::PIX_W-1:0]           rp_pxl,
	input  logic                                 rp_first,
	input  logic [$clog2(OUT_CH)-1:0]            rp_channel,
	input  logic signed [conv_pkg::WGT_W-1:0]    kernel [conv_pkg::K_TAPS],
	output logic                                 res_valid,
	output logic signed [conv_pkg::ACC_W-1:0]    res_data,
	output logic [$clog2(OUT_CH)-1:0]            res_channel
);

	import conv_pkg::*;

	localparam int CW = $clog2(IMG_W);

	localparam logic [CW-1:0] COL_LAST = CW'(IMG_W - 1);

	logic [CW-1:0] col_cnt;
	logic [CW-1:0] row_cnt;
	logic [CW-1:0] col_now;
	logic [CW-1:0] row_now;

	// line_buf[0] holds the row above, line_buf[1] the row above that
	logic [PIX_W-1:0] line_buf [2][IMG_W];
	logic [PIX_W-1:0] col_in   [3];
	logic [PIX_W-1:0] win      [K_TAPS];

	logic                    win_valid;
	logic [$clog2(OUT_CH)-1:0] win_channel;
	logic signed [ACC_W-1:0] mac_sum;

	//////////////////////////////////////////////////////////////////////
	// Position of the incoming pixel
	//////////////////////////////////////////////////////////////////////

	assign col_now = rp_first ? '0 : col_cnt;
	assign row_now = rp_first ? '0 : row_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (rp_valid) begin
			if (col_now == COL_LAST) begin
				col_cnt <= '0;
				row_cnt <= row_now + 1'b1;
			end else begin
				col_cnt <= col_now + 1'b1;
				row_cnt <= row_now;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Line buffers and 3x3 window
	//////////////////////////////////////////////////////////////////////

	// New window column, top to bottom
	assign col_in[0] = line_buf[1][IMG_W-1];
	assign col_in[1] = line_buf[0][IMG_W-1];
	assign col_in[2] = rp_pxl;

	always_ff @(posedge clk) begin
		if (rp_valid) begin
			for (int b = 0; b < 2; b++) begin
				line_buf[b][0] <= (b == 0) ? rp_pxl : line_buf[0][IMG_W-1];
				for (int i = 1; i < IMG_W; i++)
					line_buf[b][i] <= line_buf[b][i-1];
			end
			// Window shifts left, newest column on the right
			for (int r = 0; r < 3; r++) begin
				win[r*3]     <= win[r*3 + 1];
				win[r*3 + 1] <= win[r*3 + 2];
				win[r*3 + 2] <= col_in[r];
			end
		end
	end

	// Window is complete once two rows and two columns precede it
	always_ff @(posedge clk) begin
		if (reset)
			win_valid <= 1'b0;
		else
			win_valid <= rp_valid && (row_now >= CW'(2)) && (col_now >= CW'(2));
		win_channel <= rp_channel;
	end

	//////////////////////////////////////////////////////////////////////
	// Multiply-accumulate
	//////////////////////////////////////////////////////////////////////

	// Pixels are zero-extended so the product stays signed
	always_comb begin
		mac_sum = '0;
		for (int t = 0; t < K_TAPS; t++)
			mac_sum = mac_sum + ACC_W'($signed({1'b0, win[t]}) * kernel[t]);
	end

	always_ff @(posedge clk) begin
		if (reset)
			res_valid <= 1'b0;
		else
			res_valid <= win_valid;
		res_data    <= mac_sum;
		res_channel <= win_channel;
	end

	// Back-to-back results always belong to one channel
	a_channel_gap: assert property (
		@(posedge clk) disable iff (reset)
		(res_valid ##1 res_valid) |-> (res_channel == $past(res_channel))
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the convolution layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module conv_layer_tb --Mdir "$OBJ" \
	-f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/Vconv_layer_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^No errors$" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// ==== tb.f ====
+incdir+verification
rtl/conv_pkg.sv
rtl/frame_replay_buffer.sv
rtl/kernel_store.sv
rtl/window_mac.sv
rtl/conv_layer_top.sv
verification/conv_layer_tb.sv

// ==== verification/conv_model.svh ====
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// Largest positive value of a result
localparam longint ACC_MAX = (longint'(1) <<< (ACC_W - 1)) - 1;

// Copies of everything loaded into the DUT
logic signed [WGT_W-1:0] model_wgt   [N_CH*K_TAPS];
logic [PIX_W-1:0]        model_frame [IMG_SIDE*IMG_SIDE];

// Expected results, oldest first
logic signed [ACC_W-1:0] exp_data [$];
logic [CH_W-1:0]         exp_chan [$];

// Kernel store comes out of reset all zero
function automatic void clear_model_weights();
	for (int i = 0; i < N_CH * K_TAPS; i++)
		model_wgt[i] = '0;
endfunction

// One valid-convolution sum, window top-left at (row, col)
function automatic logic signed [ACC_W-1:0] window_sum(int ch, int row, int col);
	longint sum;
	longint pix;
	longint w;
	sum = 0;
	for (int r = 0; r < 3; r++) begin
		for (int c = 0; c < 3; c++) begin
			pix = longint'(model_frame[(row + r) * IMG_SIDE + col + c]);
			w   = longint'(model_wgt[ch * K_TAPS + r * 3 + c]);
			sum = sum + pix * w;
		end
	end
	// Exact sum has to fit the result width
	if (sum > ACC_MAX || sum < -ACC_MAX - 1)
		abort_run($sformatf("Model sum %0d does not fit in %0d bits", sum, ACC_W));
	return ACC_W'(sum);
endfunction

//////////////////////////////////////////////////////////////////////
// Whole layer: channels in order, windows in raster order
//////////////////////////////////////////////////////////////////////

function automatic void predict_layer();
	for (int ch = 0; ch < N_CH; ch++) begin
		for (int row = 0; row < IMG_SIDE - 2; row++) begin
			for (int col = 0; col < IMG_SIDE - 2; col++) begin
				exp_data.push_back(window_sum(ch, row, col));
				exp_chan.push_back(CH_W'(ch));
			end
		end
	end
endfunction

`endif

// ==== verification/conv_layer_tb.sv ====
`timescale 1ns/1ps

module conv_layer_tb;

	import conv_pkg::*;

	localparam int IMG_SIDE  = 8;
	localparam int N_CH      = 4;
	localparam int GAP_CYC   = 4;
	localparam int CH_W      = $clog2(N_CH);
	localparam int WA_W      = $clog2(N_CH * K_TAPS);
	localparam int LAYER_RES = N_CH * (IMG_SIDE - 2) * (IMG_SIDE - 2);
	localparam int N_LAYERS  = 7;
	localparam int WATCHDOG_CYC =
		2 * N_LAYERS * (IMG_SIDE * IMG_SIDE + N_CH * (IMG_SIDE * IMG_SIDE + GAP_CYC + 4));
	localparam logic [31:0] RAND_SEED = 32'h96e5_4986;

	logic                    clk;
	logic                    reset;
	logic                    pxl_valid;
	logic [PIX_W-1:0]        pxl_in;
	logic                    in_ready;
	logic                    wgt_we;
	logic [WA_W-1:0]         wgt_addr;
	logic signed [WGT_W-1:0] wgt_data;
	logic                    res_valid;
	logic signed [ACC_W-1:0] res_data;
	logic [CH_W-1:0]         res_channel;
	logic                    layer_done;

	string test_name;
	int    layer_results = 0;
	int    done_count = 0;

	function automatic void abort_run(string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "Simulation stopped");
	endfunction

	`include "conv_model.svh"

	conv_layer_top #(
		.IMG_W (IMG_SIDE),
		.OUT_CH(N_CH),
		.GAP   (GAP_CYC)
	) dut (
		.clk        (clk),
		.reset      (reset),
		.pxl_valid  (pxl_valid),
		.pxl_in     (pxl_in),
		.in_ready   (in_ready),
		.wgt_we     (wgt_we),
		.wgt_addr   (wgt_addr),
		.wgt_data   (wgt_data),
		.res_valid  (res_valid),
		.res_data   (res_data),
		.res_channel(res_channel),
		.layer_done (layer_done)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic compare_result(string name, logic signed [ACC_W-1:0] exp,
			logic signed [ACC_W-1:0] act);
		if (exp !== act)
			abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic compare_channel(string name, logic [CH_W-1:0] exp, logic [CH_W-1:0] act);
		if (exp !== act)
			abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic compare_count(string name, int exp, int act);
		if (exp != act)
			abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic compare_flag(string name, logic exp, logic act);
		if (exp !== act)
			abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	// Results checked against the model, stable mid-cycle
	always @(negedge clk) begin
		if (res_valid === 1'b1) begin
			if (exp_data.size() == 0)
				abort_run($sformatf("%s: result arrived when none was expected", test_name));
			compare_result({test_name, " data"}, exp_data.pop_front(), res_data);
			compare_channel({test_name, " channel"}, exp_chan.pop_front(), res_channel);
			layer_results++;
		end
		if (layer_done === 1'b1) begin
			compare_count({test_name, " results per layer"}, LAYER_RES, layer_results);
			layer_results = 0;
			done_count++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		abort_run($sformatf("Timeout: the run hung for %0d cycles", WATCHDOG_CYC));
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus, always entered and left on a falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic load_kernels(int first_ch, int last_ch, bit rand_w,
			logic signed [WGT_W-1:0] fixed);
		logic signed [WGT_W-1:0] w;
		for (int ch = first_ch; ch <= last_ch; ch++) begin
			for (int t = 0; t < K_TAPS; t++) begin
				w = rand_w ? WGT_W'($urandom) : fixed;
				model_wgt[ch * K_TAPS + t] = w;
				wgt_we   = 1'b1;
				wgt_addr = WA_W'(ch * K_TAPS + t);
				wgt_data = w;
				@(negedge clk);
				wgt_we = 1'b0;
			end
		end
	endtask

	task automatic send_frame(bit rand_pix, logic [PIX_W-1:0] fixed, int max_idle);
		int               idle;
		logic [PIX_W-1:0] pix;
		for (int i = 0; i < IMG_SIDE * IMG_SIDE; i++) begin
			idle = $urandom_range(max_idle, 0);
			repeat (idle) @(negedge clk);
			compare_flag({test_name, " in_ready during fill"}, 1'b1, in_ready);
			pix = rand_pix ? PIX_W'($urandom) : fixed;
			model_frame[i] = pix;
			pxl_valid = 1'b1;
			pxl_in    = pix;
			@(negedge clk);
			pxl_valid = 1'b0;
		end
	endtask

	task automatic run_layer(string name, bit rand_pix, logic [PIX_W-1:0] fixed, int max_idle);
		int done_before;
		test_name   = name;
		done_before = done_count;
		send_frame(rand_pix, fixed, max_idle);
		predict_layer();
		while (layer_done !== 1'b1) begin
			compare_flag({name, " in_ready while busy"}, 1'b0, in_ready);
			@(negedge clk);
		end
		@(negedge clk);
		compare_flag({name, " in_ready after layer"}, 1'b1, in_ready);
		compare_count({name, " layer_done pulses"}, done_before + 1, done_count);
		compare_count({name, " results left over"}, 0, exp_data.size());
	endtask

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		pxl_valid = 1'b0;
		pxl_in    = '0;
		wgt_we    = 1'b0;
		wgt_addr  = '0;
		wgt_data  = '0;
		test_name = "reset";
		void'($urandom(RAND_SEED));
		clear_model_weights();
		repeat (5) @(negedge clk);
		reset = 1'b0;

		load_kernels(0, N_CH - 1, 1'b1, '0);
		run_layer("random frame", 1'b1, '0, 0);

		// Second layer reuses three kernels unchanged
		load_kernels(2, 2, 1'b1, '0);
		run_layer("reload channel 2", 1'b1, '0, 0);

		run_layer("frame with idle gaps", 1'b1, '0, 3);

		// Most negative and most positive sums
		load_kernels(0, N_CH - 1, 1'b0, 8'sh80);
		run_layer("max pixels, min weights", 1'b0, 8'hff, 0);
		load_kernels(0, N_CH - 1, 1'b0, 8'sh7f);
		run_layer("max pixels, max weights", 1'b0, 8'hff, 0);

		test_name = "reset mid replay";
		load_kernels(0, N_CH - 1, 1'b1, '0);
		send_frame(1'b1, '0, 0);
		predict_layer();
		while (!(res_valid === 1'b1 && res_channel == CH_W'(2)))
			@(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		compare_flag("res_valid in reset", 1'b0, res_valid);
		compare_flag("layer_done in reset", 1'b0, layer_done);
		compare_flag("in_ready in reset", 1'b1, in_ready);
		exp_data.delete();
		exp_chan.delete();
		layer_results = 0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		clear_model_weights();
		run_layer("zero weights after reset", 1'b1, '0, 0);

		compare_count("total layer_done pulses", N_LAYERS - 1, done_count);
		$display("No errors");
		$finish;
	end

endmodule
